/* logic/tcdm_pkg.sv */
/*
 * Shared word and byte-enable types plus default sizes for the tile-group TCDM.
 * Imported by the bank interface, the banks, the crossbar and the top level.
 */
package tcdm_pkg;

  // Memory word
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   strb_t;

  // ----------------------------------------------------------
  // Group defaults
  // ----------------------------------------------------------

  // Tile count must stay a power of two
  localparam int unsigned DefaultNumTiles  = 4;
  localparam int unsigned DefaultBankWords = 256;

endpackage

/* logic/tcdm_bank_if.sv */
/*
 * One crossbar-to-bank channel: valid/ready request plus registered read response.
 * The crossbar takes the xbar modport, each bank the bank modport.
 */
`timescale 1ns/10ps

interface tcdm_bank_if
  import tcdm_pkg::*;
#(
  parameter int unsigned RowWidth = $clog2(DefaultBankWords),
  parameter int unsigned IdWidth  = $clog2(DefaultNumTiles)
) ();

  // Request channel
  logic                req_valid;
  logic                req_ready;
  logic [RowWidth-1:0] row;
  logic [IdWidth-1:0]  ini_id;
  logic                wen;
  data_t               wdata;
  strb_t               be;

  // Read response channel
  logic                resp_valid;
  logic                resp_ready;
  logic [IdWidth-1:0]  resp_ini_id;
  data_t               rdata;

  modport xbar (
    output req_valid, row, ini_id, wen, wdata, be, resp_ready,
    input  req_ready, resp_valid, resp_ini_id, rdata
  );

  modport bank (
    input  req_valid, row, ini_id, wen, wdata, be, resp_ready,
    output req_ready, resp_valid, resp_ini_id, rdata
  );

endinterface

/* logic/rr_arbiter.sv */
/*
 * Round-robin arbiter with a rotating priority pointer and combinational grant.
 * Shared by the crossbar for bank requests and for read responses.
 */
`timescale 1ns/10ps

module rr_arbiter #(
  parameter int unsigned NumReq = 4
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [NumReq-1:0] req_i,
  output logic [NumReq-1:0] gnt_o,
  input  logic              advance_i
);

  localparam int unsigned IdxWidth = (NumReq > 1) ? $clog2(NumReq) : 1;

  logic [IdxWidth-1:0] ptr_q;
  logic [IdxWidth-1:0] gnt_idx;
  logic                found;

  // First requester at or after the pointer
  always_comb begin
    int unsigned cand;
    gnt_o   = '0;
    gnt_idx = ptr_q;
    found   = 1'b0;
    for (int unsigned i = 0; i < NumReq; i++) begin
      cand = (ptr_q + i) % NumReq;
      if (!found && req_i[cand]) begin
        found   = 1'b1;
        gnt_idx = cand[IdxWidth-1:0];
      end
    end
    if (found) begin
      gnt_o[gnt_idx] = 1'b1;
    end
  end

  // Park on a waiting winner, step past it once it transfers
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (found) begin
      if (!advance_i) begin
        ptr_q <= gnt_idx;
      end else if (gnt_idx == IdxWidth'(NumReq - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= gnt_idx + 1'b1;
      end
    end
  end

endmodule

/* logic/tcdm_bank.sv */
/*
 * Single-port word memory behind one crossbar channel.
 * Byte-enabled writes, one registered read response held until taken.
 */
`timescale 1ns/10ps

module tcdm_bank
  import tcdm_pkg::*;
#(
  parameter int unsigned BankWords = DefaultBankWords
) (
  input logic       clk_i,
  input logic       rst_i,
  tcdm_bank_if.bank bus
);

  data_t mem [BankWords];
  logic  active_q;
  logic  req_hs;

  // Free when the response register is empty or drains this cycle
  assign bus.req_ready = active_q && (!bus.resp_valid || bus.resp_ready);
  assign req_hs        = bus.req_valid && bus.req_ready;

  // ----------------------------------------------------------
  // Control
  // ----------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      active_q       <= 1'b0;
      bus.resp_valid <= 1'b0;
    end else begin
      active_q <= 1'b1;
      if (req_hs && !bus.wen) begin
        bus.resp_valid <= 1'b1;
      end else if (bus.resp_ready) begin
        bus.resp_valid <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // Storage and response payload
  // ----------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      if (bus.wen) begin
        for (int unsigned b = 0; b < BeWidth; b++) begin
          if (bus.be[b]) begin
            mem[bus.row][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      end else begin
        // Writes give no response
        bus.rdata       <= mem[bus.row];
        bus.resp_ini_id <= bus.ini_id;
      end
    end
  end

endmodule

/* logic/local_xbar.sv */
/*
 * Local crossbar: word-interleaved routing of master requests onto the banks.
 * Read responses return to their initiator; no registers on the data path.
 */
`timescale 1ns/10ps

module local_xbar
  import tcdm_pkg::*;
#(
  parameter int unsigned  NumTiles  = DefaultNumTiles,
  parameter int unsigned  BankWords = DefaultBankWords,
  localparam int unsigned SelWidth  = $clog2(NumTiles),
  localparam int unsigned RowWidth  = $clog2(BankWords),
  localparam int unsigned AddrWidth = SelWidth + RowWidth
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // Masters
  input  logic  [NumTiles-1:0]                req_valid_i,
  output logic  [NumTiles-1:0]                req_ready_o,
  input  logic  [NumTiles-1:0][AddrWidth-1:0] req_addr_i,
  input  logic  [NumTiles-1:0]                req_wen_i,
  input  data_t [NumTiles-1:0]                req_wdata_i,
  input  strb_t [NumTiles-1:0]                req_be_i,
  output logic  [NumTiles-1:0]                resp_valid_o,
  input  logic  [NumTiles-1:0]                resp_ready_i,
  output data_t [NumTiles-1:0]                resp_rdata_o,
  // Banks
  tcdm_bank_if.xbar                           banks [NumTiles]
);

  logic  [NumTiles-1:0][SelWidth-1:0] sel;
  logic  [NumTiles-1:0][RowWidth-1:0] row;
  // Indexed [bank][master]
  logic  [NumTiles-1:0][NumTiles-1:0] bank_req;
  logic  [NumTiles-1:0][NumTiles-1:0] bank_gnt;
  logic  [NumTiles-1:0]               bank_ready;
  // Indexed [master][bank]
  logic  [NumTiles-1:0][NumTiles-1:0] resp_req;
  logic  [NumTiles-1:0][NumTiles-1:0] resp_gnt;
  logic  [NumTiles-1:0]               bank_resp_valid;
  logic  [NumTiles-1:0][SelWidth-1:0] bank_resp_ini;
  data_t [NumTiles-1:0]               bank_rdata;

  function automatic logic [SelWidth-1:0] gnt_index(input logic [NumTiles-1:0] gnt);
    logic [SelWidth-1:0] idx;
    idx = '0;
    for (int unsigned i = 0; i < NumTiles; i++) begin
      if (gnt[i]) begin
        idx = SelWidth'(i);
      end
    end
    return idx;
  endfunction

  // Low word-address bits pick the bank
  for (genvar m = 0; m < NumTiles; m++) begin : gen_decode
    assign sel[m] = req_addr_i[m][SelWidth-1:0];
    assign row[m] = req_addr_i[m][AddrWidth-1:SelWidth];
  end

  // ----------------------------------------------------------
  // Request path, one arbiter per bank
  // ----------------------------------------------------------

  for (genvar b = 0; b < NumTiles; b++) begin : gen_bank_port
    logic [SelWidth-1:0] win;
    logic [NumTiles-1:0] taken;

    for (genvar m = 0; m < NumTiles; m++) begin : gen_match
      assign bank_req[b][m] = req_valid_i[m] && (sel[m] == SelWidth'(b));
      assign resp_req[m][b] = bank_resp_valid[b] && (bank_resp_ini[b] == SelWidth'(m));
      assign taken[m]       = resp_gnt[m][b] && resp_ready_i[m];
    end

    rr_arbiter #(
      .NumReq(NumTiles)
    ) i_req_arb (
      .clk_i    (clk_i                        ),
      .rst_i    (rst_i                        ),
      .req_i    (bank_req[b]                  ),
      .gnt_o    (bank_gnt[b]                  ),
      .advance_i((|bank_req[b]) && bank_ready[b])
    );

    assign win                 = gnt_index(bank_gnt[b]);
    assign banks[b].req_valid  = |bank_req[b];
    assign banks[b].row        = row[win];
    assign banks[b].ini_id     = win;
    assign banks[b].wen        = req_wen_i[win];
    assign banks[b].wdata      = req_wdata_i[win];
    assign banks[b].be         = req_be_i[win];
    assign bank_ready[b]       = banks[b].req_ready;

    assign bank_resp_valid[b]  = banks[b].resp_valid;
    assign bank_resp_ini[b]    = banks[b].resp_ini_id;
    assign bank_rdata[b]       = banks[b].rdata;
    assign banks[b].resp_ready = |taken;
  end

  // ----------------------------------------------------------
  // Response path, one arbiter per master
  // ----------------------------------------------------------

  for (genvar m = 0; m < NumTiles; m++) begin : gen_master_port
    logic [SelWidth-1:0] src;

    rr_arbiter #(
      .NumReq(NumTiles)
    ) i_resp_arb (
      .clk_i    (clk_i                             ),
      .rst_i    (rst_i                             ),
      .req_i    (resp_req[m]                       ),
      .gnt_o    (resp_gnt[m]                       ),
      .advance_i(resp_valid_o[m] && resp_ready_i[m])
    );

    assign src             = gnt_index(resp_gnt[m]);
    assign resp_valid_o[m] = |resp_req[m];
    assign resp_rdata_o[m] = bank_rdata[src];
    // Ready only for the winner of the addressed bank
    assign req_ready_o[m]  = bank_gnt[sel[m]][m] && bank_ready[sel[m]];
  end

endmodule

/* logic/tcdm_group.sv */
/*
 * Tile-group TCDM top: per-master request/response ports into the local
 * crossbar, with one word-interleaved bank per tile.
 */
`timescale 1ns/10ps

module tcdm_group
  import tcdm_pkg::*;
#(
  parameter int unsigned  NumTiles  = DefaultNumTiles,
  parameter int unsigned  BankWords = DefaultBankWords,
  localparam int unsigned SelWidth  = $clog2(NumTiles),
  localparam int unsigned RowWidth  = $clog2(BankWords),
  localparam int unsigned AddrWidth = SelWidth + RowWidth
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // Request channel per master
  input  logic  [NumTiles-1:0]                req_valid_i,
  output logic  [NumTiles-1:0]                req_ready_o,
  input  logic  [NumTiles-1:0][AddrWidth-1:0] req_addr_i,
  input  logic  [NumTiles-1:0]                req_wen_i,
  input  data_t [NumTiles-1:0]                req_wdata_i,
  input  strb_t [NumTiles-1:0]                req_be_i,
  // Read response channel per master
  output logic  [NumTiles-1:0]                resp_valid_o,
  input  logic  [NumTiles-1:0]                resp_ready_i,
  output data_t [NumTiles-1:0]                resp_rdata_o
);

  tcdm_bank_if #(
    .RowWidth(RowWidth),
    .IdWidth (SelWidth)
  ) bank_bus [NumTiles] ();

  local_xbar #(
    .NumTiles (NumTiles ),
    .BankWords(BankWords)
  ) i_xbar (
    .clk_i       (clk_i       ),
    .rst_i       (rst_i       ),
    .req_valid_i (req_valid_i ),
    .req_ready_o (req_ready_o ),
    .req_addr_i  (req_addr_i  ),
    .req_wen_i   (req_wen_i   ),
    .req_wdata_i (req_wdata_i ),
    .req_be_i    (req_be_i    ),
    .resp_valid_o(resp_valid_o),
    .resp_ready_i(resp_ready_i),
    .resp_rdata_o(resp_rdata_o),
    .banks       (bank_bus    )
  );

  // One bank per tile
  for (genvar t = 0; t < NumTiles; t++) begin : gen_tiles
    tcdm_bank #(
      .BankWords(BankWords)
    ) i_bank (
      .clk_i(clk_i      ),
      .rst_i(rst_i      ),
      .bus  (bank_bus[t])
    );
  end

endmodule

/* sim/clk_gen.sv */
/*
 * Testbench clock and reset source: 10 ns clock, reset held for the first cycles.
 */
`timescale 1ns/10ps

module clk_gen #(
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_o <= 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

/* sim/tcdm_group_assert.sv */
/*
 * Concurrent checks on the tile-group handshakes, bound into tcdm_group by the testbench.
 */
`timescale 1ns/10ps

module tcdm_group_assert
  import tcdm_pkg::*;
#(
  parameter int unsigned NumTiles = DefaultNumTiles
) (
  input logic                 clk_i,
  input logic                 rst_i,
  input logic  [NumTiles-1:0] req_ready_o,
  input logic  [NumTiles-1:0] resp_valid_o,
  input logic  [NumTiles-1:0] resp_ready_i,
  input data_t [NumTiles-1:0] resp_rdata_o
);

  // Number of failed assertions
  int fail_count = 0;

  // Ports stay quiet while reset is held
  a_reset_quiet: assert property (
    @(posedge clk_i) rst_i ##1 rst_i |-> (req_ready_o == '0) && (resp_valid_o == '0)
  ) else begin
    $error("ready or response valid raised during reset");
    fail_count++;
  end

  // A stalled response keeps its valid and its word
  for (genvar m = 0; m < NumTiles; m++) begin : gen_master
    a_resp_hold: assert property (
      @(posedge clk_i) disable iff (rst_i)
      resp_valid_o[m] && !resp_ready_i[m] |=> resp_valid_o[m] && $stable(resp_rdata_o[m])
    ) else begin
      $error("response on master %0d dropped or changed before ready", m);
      fail_count++;
    end
  end

endmodule

/* sim/tb_tcdm_group.sv */
/*
 * Table-driven testbench for the tile-group TCDM. Entries sharing a step number
 * are issued together; a reference memory supplies the expected read words.
 */
`timescale 1ns/10ps

module tb_tcdm_group
  import tcdm_pkg::*;
();

  localparam int unsigned NumTiles    = 4;
  localparam int unsigned BankWords   = 256;
  localparam int unsigned SelWidth    = $clog2(NumTiles);
  localparam int unsigned AddrWidth   = SelWidth + $clog2(BankWords);
  localparam int          StepTimeout = 40;

  typedef struct packed {
    logic [7:0]           step;
    logic [SelWidth-1:0]  master;
    logic                 wen;
    logic [AddrWidth-1:0] addr;
    data_t                data;
    strb_t                be;
    data_t                exp;
    logic [3:0]           dly;
    logic [3:0]           hold;
    logic                 fast;
  } entry_t;

  logic                                clk_i;
  logic                                rst_i;
  logic  [NumTiles-1:0]                req_valid_i;
  logic  [NumTiles-1:0]                req_ready_o;
  logic  [NumTiles-1:0][AddrWidth-1:0] req_addr_i;
  logic  [NumTiles-1:0]                req_wen_i;
  data_t [NumTiles-1:0]                req_wdata_i;
  strb_t [NumTiles-1:0]                req_be_i;
  logic  [NumTiles-1:0]                resp_valid_o;
  logic  [NumTiles-1:0]                resp_ready_i;
  data_t [NumTiles-1:0]                resp_rdata_o;

  entry_t tbl [$];
  string  names [$];
  data_t  ref_mem [1 << AddrWidth];
  integer seed = 32'h9513_0650;
  int     checks;
  int     mismatches;
  int     timeouts;

  clk_gen #(.ResetCycles(8)) i_clk_gen (.clk_o(clk_i), .rst_o(rst_i));

  tcdm_group #(.NumTiles(NumTiles), .BankWords(BankWords)) UUT (.*);

  bind tcdm_group tcdm_group_assert #(.NumTiles(NumTiles)) i_assert (.*);

  task automatic check_data(input string name, input data_t exp, input data_t act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // Reference model update and table entry
  task automatic add_entry(input string name, input int step, input int master, input bit wen,
                           input int addr, input strb_t be, input int dly, input int hold,
                           input bit fast);
    entry_t e;
    e        = '0;
    e.step   = 8'(step);
    e.master = SelWidth'(master);
    e.wen    = wen;
    e.addr   = AddrWidth'(addr);
    e.be     = be;
    e.dly    = 4'(dly);
    e.hold   = 4'(hold);
    e.fast   = fast;
    if (wen) begin
      e.data = $random(seed);
      for (int unsigned b = 0; b < BeWidth; b++) begin
        if (be[b]) begin
          ref_mem[addr][8*b +: 8] = e.data[8*b +: 8];
        end
      end
    end else begin
      e.exp = ref_mem[addr];
    end
    tbl.push_back(e);
    names.push_back(name);
  endtask

  task automatic build_table();
    for (int b = 0; b < 4; b++) begin
      add_entry($sformatf("write bank %0d", b), 1 + b, 0, 1'b1, 16 + b, 4'hf, 0, 0, 1'b0);
    end
    for (int b = 0; b < 4; b++) begin
      add_entry($sformatf("read back bank %0d", b), 5 + b, (b + 1) % 4, 1'b0, 16 + b, 4'hf,
                0, 0, 1'b0);
    end
    add_entry("be full write", 9, 1, 1'b1, 40, 4'b1111, 0, 0, 1'b0);
    add_entry("be bytes 0 and 2", 10, 2, 1'b1, 40, 4'b0101, 0, 0, 1'b0);
    add_entry("be byte 3", 11, 3, 1'b1, 40, 4'b1000, 0, 0, 1'b0);
    add_entry("be merged read", 12, 0, 1'b0, 40, 4'b1111, 0, 0, 1'b0);
    for (int m = 0; m < 4; m++) begin
      add_entry($sformatf("parallel read m%0d", m), 13, m, 1'b0, 16 + (m + 2) % 4, 4'hf,
                0, 0, 1'b1);
    end
    // Bank 1 contention, writes then reads
    for (int m = 0; m < 4; m++) begin
      add_entry($sformatf("conflict write m%0d", m), 14, m, 1'b1, 33 + 4 * m, 4'hf, 0, 0, 1'b0);
    end
    for (int m = 0; m < 4; m++) begin
      add_entry($sformatf("conflict read m%0d", m), 15, m, 1'b0, 33 + 4 * ((m + 1) % 4), 4'hf,
                0, 0, 1'b0);
    end
    add_entry("held read", 16, 2, 1'b0, 17, 4'hf, 0, 6, 1'b0);
    add_entry("blocked write", 16, 3, 1'b1, 21, 4'hf, 2, 0, 1'b0);
    add_entry("read after release", 17, 0, 1'b0, 21, 4'hf, 0, 0, 1'b0);
  endtask

  // ------------------------------------------------------------
  // One step: drive on the rising edge, sample on the falling edge
  // ------------------------------------------------------------

  task automatic run_step(input int first, input int last);
    int                  ent [NumTiles];
    int                  waits [NumTiles];
    int                  hold_left [NumTiles];
    logic [NumTiles-1:0] req_pend;
    logic [NumTiles-1:0] rsp_pend;
    logic [NumTiles-1:0] hs;
    int                  cycles;
    entry_t              e;
    req_pend = '0;
    rsp_pend = '0;
    for (int m = 0; m < NumTiles; m++) begin
      ent[m]       = -1;
      waits[m]     = 0;
      hold_left[m] = 0;
    end
    for (int i = first; i <= last; i++) begin
      e                   = tbl[i];
      ent[e.master]       = i;
      req_pend[e.master]  = 1'b1;
      rsp_pend[e.master]  = !e.wen;
      hold_left[e.master] = int'(e.hold);
    end
    cycles = 0;
    while ((req_pend | rsp_pend) != '0 && cycles < StepTimeout) begin
      @(posedge clk_i);
      for (int m = 0; m < NumTiles; m++) begin
        if (ent[m] >= 0) begin
          e = tbl[ent[m]];
          req_valid_i[m]  <= req_pend[m] && (cycles >= int'(e.dly));
          req_addr_i[m]   <= e.addr;
          req_wen_i[m]    <= e.wen;
          req_wdata_i[m]  <= e.data;
          req_be_i[m]     <= e.be;
          resp_ready_i[m] <= (hold_left[m] == 0);
        end
      end
      @(negedge clk_i);
      hs = req_valid_i & req_ready_o;
      for (int m = 0; m < NumTiles; m++) begin
        if (ent[m] >= 0) begin
          e = tbl[ent[m]];
          if (rsp_pend[m] && !req_pend[m] && resp_valid_o[m]) begin
            if (resp_ready_i[m]) begin
              check_data(names[ent[m]], e.exp, resp_rdata_o[m]);
              rsp_pend[m] = 1'b0;
            end else begin
              check_data({names[ent[m]], " held"}, e.exp, resp_rdata_o[m]);
              hold_left[m]--;
              // Same bank must stall behind the pending response
              for (int k = 0; k < NumTiles; k++) begin
                if (k != m && req_valid_i[k] &&
                    req_addr_i[k][SelWidth-1:0] == req_addr_i[m][SelWidth-1:0]) begin
                  check_flag({names[ent[k]], " stalled"}, 1'b0, req_ready_o[k]);
                end
              end
            end
          end
          if (cycles == 0 && e.fast) begin
            check_flag({names[ent[m]], " same cycle"}, 1'b1, req_ready_o[m]);
          end
          if (req_pend[m] && hs[m]) begin
            check_flag({names[ent[m]], " wait bound"}, 1'b1, waits[m] < NumTiles);
            req_pend[m] = 1'b0;
          end else if (req_valid_i[m]) begin
            for (int k = 0; k < NumTiles; k++) begin
              if (hs[k] && req_addr_i[k][SelWidth-1:0] == req_addr_i[m][SelWidth-1:0]) begin
                waits[m]++;
              end
            end
          end
        end
      end
      cycles++;
    end
    if ((req_pend | rsp_pend) != '0) begin
      timeouts++;
      $display("Timeout: step %0d still waiting after %0d cycles", tbl[first].step, cycles);
    end
    @(posedge clk_i);
    req_valid_i  <= '0;
    resp_ready_i <= '1;
  endtask

  initial begin
    int cycles;
    int i;
    int j;
    // Reads to every bank stay raised through reset and must not be taken
    req_valid_i  <= '1;
    req_wen_i    <= '0;
    req_wdata_i  <= '0;
    req_be_i     <= '0;
    resp_ready_i <= '1;
    for (int m = 0; m < NumTiles; m++) begin
      req_addr_i[m] <= AddrWidth'(m);
    end
    checks     = 0;
    mismatches = 0;
    timeouts   = 0;
    build_table();
    @(posedge clk_i);
    cycles = 0;
    while (rst_i && cycles < 50) begin
      @(negedge clk_i);
      check_flag("reset req ready", 1'b0, |req_ready_o);
      check_flag("reset resp valid", 1'b0, |resp_valid_o);
      cycles++;
    end
    if (rst_i) begin
      timeouts++;
      $display("Timeout: reset was never released");
    end
    @(posedge clk_i);
    req_valid_i <= '0;
    i = 0;
    while (i < tbl.size()) begin
      j = i;
      while (j + 1 < tbl.size() && tbl[j + 1].step == tbl[i].step) begin
        j++;
      end
      run_step(i, j);
      i = j + 1;
    end
    $display("Checks: %0d, mismatches: %0d, timeouts: %0d, assertion failures: %0d",
             checks, mismatches, timeouts, UUT.i_assert.fail_count);
    if (mismatches == 0 && timeouts == 0 && UUT.i_assert.fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* sources.f */
logic/tcdm_pkg.sv
logic/tcdm_bank_if.sv
logic/rr_arbiter.sv
logic/tcdm_bank.sv
logic/local_xbar.sv
logic/tcdm_group.sv
sim/clk_gen.sv
sim/tcdm_group_assert.sv
sim/tb_tcdm_group.sv

/* Makefile */
# Verilator build and run of the tile-group TCDM testbench
VERILATOR ?= verilator
TOP       ?= tb_tcdm_group
SEED      ?= 1
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sources.f
	$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
